// ==== vlog.f ====
+incdir+test
verilog/draw_pkg.sv
verilog/draw_ctrl.sv
verilog/pace_timer.sv
verilog/line_walker.sv
verilog/bitmap_addr.sv
verilog/fb_bram.sv
verilog/line_draw_top.sv
test/tb_line_draw.sv

// ==== test/tb_line_ref.svh ====
// ******************************
// reference line model for the testbench
// Bresenham walk into a model framebuffer
// ******************************
`ifndef TB_LINE_REF_SVH
`define TB_LINE_REF_SVH

draw_pkg::cidx_t model_fb [NPIX];  // expected framebuffer contents

// blank model, like the RAM at power-up
function automatic void model_clear();
    for (int i = 0; i < NPIX; i++) model_fb[i] = '0;
endfunction

// draws one command into model_fb and returns the number of points visited
function automatic int draw_ref(input draw_pkg::line_cmd_t c);
    int x, y, xe, ye, dx, dy, sx, sy, err, e2, n;
    x   = $signed(c.x0);
    y   = $signed(c.y0);
    xe  = $signed(c.x1);
    ye  = $signed(c.y1);
    dx  = (xe > x) ? xe - x : x - xe;
    dy  = (ye > y) ? y - ye : ye - y;  // kept negative
    sx  = (x < xe) ? 1 : -1;
    sy  = (y < ye) ? 1 : -1;
    err = dx + dy;
    n   = 0;
    while (1) begin
        if (x >= 0 && x < FB_W && y >= 0 && y < FB_H)
            model_fb[y * FB_W + x] = c.cidx;  // later lines win
        n++;
        if (x == xe && y == ye)
            break;  // end point included
        e2 = 2 * err;
        if (e2 >= dy) begin
            err += dy;
            x   += sx;
        end
        if (e2 <= dx) begin
            err += dx;
            y   += sy;
        end
    end
    return n;
endfunction

`endif

// ==== test/tb_line_draw.sv ====
// ******************************
// testbench for line_draw_top
// directed and random lines, full readback
// ******************************
`timescale 1ns/100ps

module tb_line_draw;

    localparam int FB_W   = 160;
    localparam int FB_H   = 90;
    localparam int PACE   = 3;
    localparam int NPIX   = FB_W * FB_H;
    localparam int AW     = $clog2(NPIX);
    localparam int N_RAND = 40;
    localparam int SEED   = 32'h3503_df9b;
    localparam int STIM   = 2;  // drive delay after rising edge, ns

    logic                clk_sys, rst_sys, req, ack, busy;
    draw_pkg::line_cmd_t cmd;
    logic [AW-1:0]       raddr;
    draw_pkg::cidx_t     rdata;

    int   cycles = 0;
    int   limit  = 40;  // reset and setup, grows per command
    event chk_go, chk_end;

    `include "tb_line_ref.svh"

    line_draw_top #(.FB_WIDTH(FB_W), .FB_HEIGHT(FB_H), .PACE_DIV(PACE)) uut (
        .clk_sys, .rst_sys, .req, .cmd, .ack, .busy, .raddr, .rdata
    );

    initial begin
        clk_sys = 1'b0;
        forever #20 clk_sys = ~clk_sys;  // 40 ns period
    end

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    always @(posedge clk_sys) begin
        cycles <= cycles + 1;
        if (cycles > limit)
            stop_with_failure("timeout: the line drawing did not finish in time");
    end

    task automatic next_cycle();
        @(posedge clk_sys);
        #STIM;
    endtask

    // compares the whole framebuffer against the model, pipelined reads
    initial begin
        raddr = '0;
        forever begin
            @(chk_go);
            for (int a = 0; a <= NPIX; a++) begin
                next_cycle();
                if (a > 0)
                    assert (rdata === model_fb[a-1]) else stop_with_failure($sformatf(
                        "FAILED rdata at address %h: got %h, expected %h",
                        a - 1, rdata, model_fb[a-1]));
                if (a < NPIX)
                    raddr = AW'(a);  // data back next cycle
            end
            -> chk_end;
        end
    end

    // one full four-phase transaction, then readback
    task automatic send_line(input int x0, input int y0, input int x1, input int y1,
                             input int col);
        draw_pkg::line_cmd_t c;
        int n, t_req, hold;
        c.x0   = x0[draw_pkg::CORDW-1:0];
        c.y0   = y0[draw_pkg::CORDW-1:0];
        c.x1   = x1[draw_pkg::CORDW-1:0];
        c.y1   = y1[draw_pkg::CORDW-1:0];
        c.cidx = col[draw_pkg::CIDXW-1:0];
        n      = draw_ref(c);             // model updated up front
        limit += n * PACE + 20 + NPIX + 2;  // drawing plus readback
        assert (!ack) else stop_with_failure("ack was high before req rose");
        cmd   = c;
        req   = 1'b1;
        t_req = cycles;
        next_cycle();
        while (!ack) begin
            assert (busy) else stop_with_failure("busy was low while the line was drawing");
            next_cycle();
        end
        assert (cycles - t_req >= n * PACE) else stop_with_failure($sformatf(
            "ack came %0d cycles after req, too soon for %0d pixels",
            cycles - t_req, n));
        assert (!busy) else stop_with_failure("busy was still high when ack rose");
        hold = $urandom_range(4) + 1;  // keep req high a few cycles
        repeat (hold) begin
            next_cycle();
            assert (ack) else stop_with_failure("ack dropped while req was still held");
        end
        req = 1'b0;
        next_cycle();
        assert (!ack) else stop_with_failure("ack did not fall one cycle after req fell");
        -> chk_go;
        @(chk_end);
    endtask

    function automatic int rand_coord();
        return int'($urandom_range(200)) - 20;  // -20 to 180
    endfunction

    initial begin
        void'($urandom(SEED));
        rst_sys   = 1'b1;
        req       = 1'b0;
        cmd       = '0;
        model_clear();
        repeat (3) @(posedge clk_sys);
        #STIM;
        rst_sys = 1'b0;
        assert (!ack && !busy) else stop_with_failure("ack or busy was high after reset");
        send_line(10, 20, 60, 20, 1);    // horizontal
        send_line(30, 5, 30, 70, 2);     // vertical
        send_line(0, 0, 40, 40, 3);      // 45 degrees
        send_line(80, 45, 120, 55, 4);   // eight octants from the centre
        send_line(80, 45, 90, 80, 5);
        send_line(80, 45, 70, 85, 6);
        send_line(80, 45, 40, 55, 7);
        send_line(80, 45, 40, 35, 8);
        send_line(80, 45, 70, 5, 9);
        send_line(80, 45, 90, 10, 10);
        send_line(80, 45, 120, 35, 11);
        send_line(5, 5, 5, 5, 12);       // single point
        send_line(-10, -5, 170, 95, 13); // clipped at both ends
        send_line(150, 80, 200, 100, 14);
        send_line(-30, 40, 10, 40, 15);  // no wrap into row 39
        send_line(155, 10, 175, 12, 1);  // no wrap into row 11
        send_line(0, 60, 159, 60, 3);    // overlap, later colour wins
        send_line(80, 0, 80, 89, 9);
        for (int i = 0; i < N_RAND; i++)
            send_line(rand_coord(), rand_coord(), rand_coord(), rand_coord(),
                      $urandom_range(15));
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== verilog/line_draw_top.sv ====
// ******************************
// line_draw_top: line drawing into a framebuffer
// ******************************
`timescale 1ns/100ps

module line_draw_top #(
    parameter  int FB_WIDTH  = 160,  // framebuffer width, pixels
    parameter  int FB_HEIGHT = 90,   // framebuffer height, pixels
    parameter  int PACE_DIV  = 1,    // cycles per drawn pixel
    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT,
    localparam int FB_ADDRW  = $clog2(FB_PIXELS)
) (
    input  logic                clk_sys,
    input  logic                rst_sys,
    input  logic                req,
    input  draw_pkg::line_cmd_t cmd,
    output logic                ack,
    output logic                busy,
    input  logic [FB_ADDRW-1:0] raddr,  // readback port
    output draw_pkg::cidx_t     rdata
);

    draw_pkg::line_cmd_t cmd_q;  // command held for the walker
    draw_pkg::pixel_t    pix;
    logic                start, run, step, done, pix_valid;
    logic                we;
    logic [FB_ADDRW-1:0] waddr;
    draw_pkg::cidx_t     wdata;

    draw_ctrl ctrl_inst (
        .clk_sys, .rst_sys,
        .req, .cmd, .ack, .busy,
        .start, .cmd_q, .run, .done
    );

    pace_timer #(.PACE_DIV(PACE_DIV)) pace_inst (
        .clk_sys, .rst_sys,
        .run, .step
    );

    line_walker walker_inst (
        .clk_sys, .rst_sys,
        .start, .cmd(cmd_q), .step,
        .pix, .pix_valid, .done
    );

    // 3-cycle address pipe, matches draw_pkg::LAT_ADDR
    bitmap_addr #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) addr_inst (
        .clk_sys, .rst_sys,
        .pix, .pix_valid,
        .we, .waddr, .wdata
    );

    fb_bram #(.DEPTH(FB_PIXELS)) fb_inst (
        .clk_sys,
        .we, .waddr, .wdata,
        .raddr, .rdata
    );

endmodule

// ==== verilog/fb_bram.sv ====
// ******************************
// fb_bram: simple dual-port framebuffer RAM
// ******************************
`timescale 1ns/100ps

module fb_bram #(
    parameter  int DEPTH = 14400,  // pixels
    localparam int ADDRW = $clog2(DEPTH)
) (
    input  logic             clk_sys,
    input  logic             we,
    input  logic [ADDRW-1:0] waddr,
    input  draw_pkg::cidx_t  wdata,
    input  logic [ADDRW-1:0] raddr,
    output draw_pkg::cidx_t  rdata  // valid one cycle after raddr
);

    draw_pkg::cidx_t mem [DEPTH];

    // blank screen at power-up
    initial begin
        for (int i = 0; i < DEPTH; i++) mem[i] = '0;
    end

    always_ff @(posedge clk_sys) begin
        if (we) mem[waddr] <= wdata;
        rdata <= mem[raddr];  // registered read
    end

    // clipping upstream keeps writes inside the buffer
    a_waddr_range: assert property (@(posedge clk_sys)
        we |-> (waddr < DEPTH));

endmodule

// ==== verilog/bitmap_addr.sv ====
// ******************************
// bitmap_addr: pixel to framebuffer address
// three stages, clip and colour carried along
// ******************************
`timescale 1ns/100ps

module bitmap_addr #(
    parameter  int FB_WIDTH  = 160,
    parameter  int FB_HEIGHT = 90,
    localparam int ADDRW     = $clog2(FB_WIDTH * FB_HEIGHT)
) (
    input  logic             clk_sys,
    input  logic             rst_sys,
    input  draw_pkg::pixel_t pix,
    input  logic             pix_valid,
    output logic             we,     // low for clipped points
    output logic [ADDRW-1:0] waddr,
    output draw_pkg::cidx_t  wdata
);

    // stage 1 regs
    draw_pkg::coord_t x1, y1;
    draw_pkg::cidx_t  cidx1;
    logic             v1, clip1;

    // stage 2 regs
    logic [ADDRW-1:0] x2, row2;  // row2 = y * FB_WIDTH
    draw_pkg::cidx_t  cidx2;
    logic             v2, clip2;

    always_ff @(posedge clk_sys) begin
        // stage 1: register point, clip test
        x1    <= pix.x;
        y1    <= pix.y;
        cidx1 <= pix.cidx;
        clip1 <= (pix.x < 0) || (pix.x >= FB_WIDTH) || (pix.y < 0) || (pix.y >= FB_HEIGHT);
        // stage 2: row start, wraps harmlessly for clipped points
        x2    <= ADDRW'(x1);
        row2  <= ADDRW'(y1) * ADDRW'(FB_WIDTH);
        cidx2 <= cidx1;
        clip2 <= clip1;
        // stage 3: final address
        waddr <= row2 + x2;
        wdata <= cidx2;
        if (rst_sys) begin
            v1 <= 1'b0;
            v2 <= 1'b0;
            we <= 1'b0;
        end else begin
            v1 <= pix_valid;
            v2 <= v1;
            we <= v2 && !clip2;  // drop off-screen points
        end
    end

endmodule

// ==== verilog/line_walker.sv ====
// ******************************
// line_walker: integer Bresenham stepper
// one pixel out per step enable
// ******************************
`timescale 1ns/100ps

module line_walker (
    input  logic                clk_sys,
    input  logic                rst_sys,
    input  logic                start,     // load a new line
    input  draw_pkg::line_cmd_t cmd,
    input  logic                step,      // emit and advance
    output draw_pkg::pixel_t    pix,
    output logic                pix_valid,
    output logic                done       // end point on pix this cycle
);

    localparam int EW = draw_pkg::CORDW + 2;  // room for dx+dy without overflow

    draw_pkg::coord_t x, y;      // current point
    draw_pkg::coord_t xe, ye;    // end point
    draw_pkg::cidx_t  cidx;
    logic             sx, sy;    // 1: step up, 0: step down
    logic             active;    // line loaded, end not yet emitted

    logic signed [EW-1:0] dx, dy, err;
    logic signed [EW:0]   e2;    // twice the error
    logic signed [EW-1:0] dxs, dys;  // raw end point deltas
    logic signed [EW-1:0] dxa, dya;  // |dx|, -|dy|
    logic signed [EW-1:0] add_x, add_y, err_nxt;
    logic                 mv_x, mv_y;

    // setup terms from the command
    always_comb begin
        dxs = $signed(cmd.x1) - $signed(cmd.x0);
        dys = $signed(cmd.y1) - $signed(cmd.y0);
        dxa = (dxs < 0) ? -dxs : dxs;
        dya = (dys < 0) ? dys : -dys;  // dy kept negative
    end

    // one Bresenham decision
    always_comb begin
        e2      = err + err;
        mv_x    = (e2 >= dy);
        mv_y    = (e2 <= dx);
        add_x   = mv_x ? dy : '0;
        add_y   = mv_y ? dx : '0;
        err_nxt = err + add_x + add_y;
    end

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            active    <= 1'b0;
            pix_valid <= 1'b0;
            done      <= 1'b0;
        end else begin
            pix_valid <= 1'b0;
            done      <= 1'b0;
            if (start) begin
                x      <= cmd.x0;
                y      <= cmd.y0;
                xe     <= cmd.x1;
                ye     <= cmd.y1;
                cidx   <= cmd.cidx;
                sx     <= (cmd.x0 < cmd.x1);
                sy     <= (cmd.y0 < cmd.y1);
                dx     <= dxa;
                dy     <= dya;
                err    <= dxa + dya;
                active <= 1'b1;
            end else if (step && active) begin
                pix       <= '{x: x, y: y, cidx: cidx};
                pix_valid <= 1'b1;
                if (x == xe && y == ye) begin  // end point included, then stop
                    done   <= 1'b1;
                    active <= 1'b0;
                end else begin
                    err <= err_nxt;
                    if (mv_x) x <= sx ? x + 1'b1 : x - 1'b1;
                    if (mv_y) y <= sy ? y + 1'b1 : y - 1'b1;
                end
            end
        end
    end

    // once a line finishes, no pixel until the next one is loaded
    a_quiet_after_done: assert property (@(posedge clk_sys) disable iff (rst_sys)
        done |=> (!pix_valid until start));

endmodule

// ==== verilog/pace_timer.sv ====
// ******************************
// pace_timer: one step enable every PACE_DIV cycles
// ******************************
`timescale 1ns/100ps

module pace_timer #(
    parameter int PACE_DIV = 1  // cycles per pixel step
) (
    input  logic clk_sys,
    input  logic rst_sys,
    input  logic run,   // drawing active
    output logic step   // one-cycle pixel enable
);

    localparam int CW = (PACE_DIV > 1) ? $clog2(PACE_DIV) : 1;

    logic [CW-1:0] cnt;  // counts down to the next step

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            cnt  <= CW'(PACE_DIV - 1);
            step <= 1'b0;
        end else if (!run) begin
            cnt  <= CW'(PACE_DIV - 1);  // reload while idle
            step <= 1'b0;
        end else if (cnt == '0) begin
            cnt  <= CW'(PACE_DIV - 1);  // wrap
            step <= 1'b1;
        end else begin
            cnt  <= cnt - 1'b1;
            step <= 1'b0;
        end
    end

endmodule

// ==== verilog/draw_ctrl.sv ====
// ******************************
// draw_ctrl: req/ack handshake FSM
// starts the walker, waits for the write pipe to drain
// ******************************
`timescale 1ns/100ps

module draw_ctrl (
    input  logic                clk_sys,
    input  logic                rst_sys,
    input  logic                req,    // four-phase request from host
    input  draw_pkg::line_cmd_t cmd,    // stable while req high
    output logic                ack,
    output logic                busy,
    output logic                start,  // one-cycle walker load
    output draw_pkg::line_cmd_t cmd_q,  // latched command
    output logic                run,    // pacing enable
    input  logic                done    // end point left the walker
);

    localparam int DW = (draw_pkg::LAT_ADDR > 1) ? $clog2(draw_pkg::LAT_ADDR) : 1;

    typedef enum logic [1:0] {IDLE, DRAW, DRAIN, ACK} state_t;
    state_t state;

    logic [DW-1:0] cnt_drain;  // cycles spent in DRAIN

    always_ff @(posedge clk_sys) begin
        start <= 1'b0;  // pulse by default
        if (rst_sys) begin
            state     <= IDLE;
            ack       <= 1'b0;
            busy      <= 1'b0;
            run       <= 1'b0;
            start     <= 1'b0;
            cnt_drain <= '0;
        end else begin
            case (state)
                IDLE: if (req) begin  // ack already low here
                    cmd_q <= cmd;
                    start <= 1'b1;
                    run   <= 1'b1;
                    busy  <= 1'b1;
                    state <= DRAW;
                end
                DRAW: if (done) begin
                    run       <= 1'b0;  // no more steps needed
                    cnt_drain <= '0;
                    state     <= DRAIN;
                end
                DRAIN: begin
                    // last pixel reaches the RAM LAT_ADDR cycles after done
                    if (cnt_drain == DW'(draw_pkg::LAT_ADDR - 1)) begin
                        ack   <= 1'b1;
                        busy  <= 1'b0;
                        state <= ACK;
                    end else begin
                        cnt_drain <= cnt_drain + 1'b1;
                    end
                end
                ACK: if (!req) begin  // host let go, drop ack next cycle
                    ack   <= 1'b0;
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // ack only answers a live request
    a_ack_needs_req: assert property (@(posedge clk_sys) disable iff (rst_sys)
        $rose(ack) |-> req);

endmodule

// ==== verilog/draw_pkg.sv ====
// ******************************
// draw_pkg: coordinate, command and pixel types
// shared by the line drawing blocks
// ******************************

package draw_pkg;

    localparam int CORDW    = 16;  // signed coordinate width
    localparam int CIDXW    = 4;   // colour index width
    localparam int LAT_ADDR = 3;   // bitmap_addr latency in cycles

    // one signed screen coordinate
    typedef logic signed [CORDW-1:0] coord_t;

    // palette index written into the framebuffer
    typedef logic [CIDXW-1:0] cidx_t;

    // line command from the host, 68 bits
    typedef struct packed {
        coord_t x0;    // start point
        coord_t y0;
        coord_t x1;    // end point, drawn too
        coord_t y1;
        cidx_t  cidx;  // colour of every pixel on the line
    } line_cmd_t;

    // one point from the walker, 36 bits
    typedef struct packed {
        coord_t x;
        coord_t y;
        cidx_t  cidx;
    } pixel_t;

endpackage
